// File: include/tryPad_config.svh
`ifndef TRYPAD_CONFIG_SVH
`define TRYPAD_CONFIG_SVH

// ----------------------------------------------------------
// Register bus geometry
// ----------------------------------------------------------
// Data and address words share one width
`define USI_BUS_WIDTH		32
// Block select field in the address word
`define BLOCK_ADRS_WIDTH	3
// In-block CSR address field
`define CSR_ADRS_WIDTH		16
// Low CSR bits that each block actually decodes
`define CSR_ACTIVE_WIDTH	8

// Block map codes
`define GPIO_ADRS_MAP		3'd0
`define TIMER_ADRS_MAP		3'd4

// ----------------------------------------------------------
// Identity and board options
// ----------------------------------------------------------
`define SYSTEM_VERSION		16'h0001
// ASCII "TP"
`define CUSTOM_CODE			16'h5450
`define EXT_SW_NUM			12
`define GPIO_WIDTH			4
// Cycles of iMCLK before a held switch counts as long press
`define LONG_PRESS_CYCLES	200

`endif

// File: verilog/tryPadPkg.sv
`include "tryPad_config.svh"

package tryPadPkg;

	// Reserved bits left over in the header word
	localparam int usiRsvWidth = `USI_BUS_WIDTH - 1 - `BLOCK_ADRS_WIDTH - `CSR_ADRS_WIDTH;

	// One register bus word
	typedef logic [`USI_BUS_WIDTH-1:0] usiWordT;

	// Access header, also the bus address word
	typedef struct packed
	{
		// 1 = write, 0 = read
		logic wrFlag;
		logic [usiRsvWidth-1:0] reserved;
		// Target block code
		logic [`BLOCK_ADRS_WIDTH-1:0] blockSel;
		// Register offset inside the block
		logic [`CSR_ADRS_WIDTH-1:0] csrAdrs;
	} usiAdrsT;

	// ----------------------------------------------------------
	// SPI shift register views
	// ----------------------------------------------------------
	// Header phase decodes the word as an address
	// Data phase treats it as a plain word
	typedef union packed
	{
		usiAdrsT adrs;
		usiWordT word;
	} spiFrameU;

endpackage

// File: verilog/spiCsrBridge.sv
`timescale 1ns/1ps
`include "tryPad_config.svh"

module spiCsrBridge
(
	input  logic				iMCLK,
	input  logic				qnARST,
	input  logic				iSpiSck,
	input  logic				iSpiMosi,
	input  logic				iSpiCsN,
	output logic				oSpiMiso,
	output tryPadPkg::usiAdrsT	usiAdrs,
	output tryPadPkg::usiWordT	usiWd,
	output logic				usiWr,
	output logic				usiRd,
	input  tryPadPkg::usiWordT	usiRdData,
	input  logic				usiRdVd
);
	import tryPadPkg::*;

	// Frame is header word then data word
	localparam int hdrBits = `USI_BUS_WIDTH;
	localparam int frameBits = 2 * `USI_BUS_WIDTH;
	localparam int cntWidth = $clog2(frameBits + 1);
	localparam logic [cntWidth-1:0] hdrLast = cntWidth'(hdrBits - 1);
	localparam logic [cntWidth-1:0] hdrEnd = cntWidth'(hdrBits);
	localparam logic [cntWidth-1:0] frameLast = cntWidth'(frameBits - 1);
	localparam logic [cntWidth-1:0] frameEnd = cntWidth'(frameBits);

	// Two sync stages, sck has one more for edge history
	logic [2:0]				sckSync;
	logic [1:0]				mosiSync;
	logic [1:0]				csNSync;
	logic					sckRise;
	logic					sckFall;
	logic					csActive;
	logic [cntWidth-1:0]	bitCnt;
	logic					readPhase;
	spiFrameU				frame;
	spiFrameU				shiftNext;

	// ----------------------------------------------------------
	// Pin oversampling
	// ----------------------------------------------------------
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			sckSync <= '0;
			mosiSync <= '0;
			// Idle bus is deselected
			csNSync <= '1;
		end
		else
		begin
			sckSync <= {sckSync[1:0], iSpiSck};
			mosiSync <= {mosiSync[0], iSpiMosi};
			csNSync <= {csNSync[0], iSpiCsN};
		end
	end

	assign sckRise = sckSync[1] & ~sckSync[2];
	assign sckFall = ~sckSync[1] & sckSync[2];
	assign csActive = ~csNSync[1];

	// MSB first, new bit enters at the bottom
	assign shiftNext.word = {frame.word[hdrBits-2:0], mosiSync[1]};

	// Data phase of a read, miso carries the returned word
	assign readPhase = (bitCnt >= hdrEnd) & ~usiAdrs.wrFlag;

	// ----------------------------------------------------------
	// Bit counter and bus access issue
	// ----------------------------------------------------------
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			bitCnt <= '0;
			usiAdrs <= '0;
			usiWr <= 1'b0;
			usiRd <= 1'b0;
			oSpiMiso <= 1'b0;
		end
		else
		begin
			// Access strobes are single cycle
			usiWr <= 1'b0;
			usiRd <= 1'b0;
			// csN high drops any partial frame
			if (!csActive)
			begin
				bitCnt <= '0;
			end
			else if (sckRise && bitCnt != frameEnd)
			begin
				bitCnt <= bitCnt + 1'b1;
			end
			// 32nd bit completes the header
			if (csActive && sckRise && bitCnt == hdrLast)
			begin
				usiAdrs <= shiftNext.adrs;
				usiRd <= ~shiftNext.adrs.wrFlag;
			end
			// 64th bit completes the write data
			if (csActive && sckRise && bitCnt == frameLast && usiAdrs.wrFlag)
			begin
				usiWr <= 1'b1;
			end
			oSpiMiso <= csActive & readPhase & frame.word[hdrBits-1];
		end
	end

	// Write data captured with the last bit
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			usiWd <= '0;
		end
		else if (csActive && sckRise && bitCnt == frameLast)
		begin
			usiWd <= shiftNext.word;
		end
	end

	// ----------------------------------------------------------
	// Shift register
	// ----------------------------------------------------------
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			frame.word <= '0;
		end
		// Read word lands before the first data falling edge
		else if (usiRdVd)
		begin
			frame.word <= usiRdData;
		end
		else if (csActive && sckRise && !readPhase && bitCnt != frameEnd)
		begin
			frame <= shiftNext;
		end
		// Hold MSB for bit 33, then step on each falling edge
		else if (csActive && sckFall && readPhase && bitCnt > hdrEnd)
		begin
			frame.word <= {frame.word[hdrBits-2:0], 1'b0};
		end
	end

endmodule

// File: verilog/usiBus.sv
`timescale 1ns/1ps
`include "tryPad_config.svh"

module usiBus
(
	input  logic				iMCLK,
	input  logic				qnARST,
	input  tryPadPkg::usiAdrsT	usiAdrs,
	input  tryPadPkg::usiWordT	usiWd,
	input  logic				usiWr,
	input  logic				usiRd,
	input  tryPadPkg::usiWordT	gpioRd,
	input  tryPadPkg::usiWordT	timerRd,
	output tryPadPkg::usiAdrsT	slvAdrs,
	output tryPadPkg::usiWordT	slvWd,
	output logic				slvWr,
	output logic				slvRd,
	output tryPadPkg::usiWordT	usiRdData,
	output logic				usiRdVd
);

	// Block code of the read in its second stage
	logic [`BLOCK_ADRS_WIDTH-1:0] rdBlkQ;

	// ----------------------------------------------------------
	// Stage 1 broadcast to all slaves
	// ----------------------------------------------------------
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			slvAdrs <= '0;
			slvWd <= '0;
			slvWr <= 1'b0;
			slvRd <= 1'b0;
			rdBlkQ <= '0;
			usiRdVd <= 1'b0;
		end
		else
		begin
			slvAdrs <= usiAdrs;
			slvWd <= usiWd;
			slvWr <= usiWr;
			slvRd <= usiRd;
			// Follows slvRd so back to back reads keep their own code
			rdBlkQ <= slvAdrs.blockSel;
			// Stage 2 pending flag, slave data is ready here
			usiRdVd <= slvRd;
		end
	end

	// ----------------------------------------------------------
	// Read return mux
	// ----------------------------------------------------------
	always_comb
	begin
		case (rdBlkQ)
			`GPIO_ADRS_MAP:		usiRdData = gpioRd;
			`TIMER_ADRS_MAP:	usiRdData = timerRd;
			// Unmapped block
			default:			usiRdData = '0;
		endcase
	end

endmodule

// File: verilog/switchGpioBlock.sv
`timescale 1ns/1ps
`include "tryPad_config.svh"

module switchGpioBlock
(
	input  logic					iMCLK,
	input  logic					qnARST,
	input  tryPadPkg::usiAdrsT		slvAdrs,
	input  tryPadPkg::usiWordT		slvWd,
	input  logic					slvWr,
	input  logic					slvRd,
	input  logic [`EXT_SW_NUM-1:0]	iPushSw,
	output tryPadPkg::usiWordT		gpioRd,
	output logic [`GPIO_WIDTH-1:0]	oGpio
);
	import tryPadPkg::*;

	localparam int holdWidth = $clog2(`LONG_PRESS_CYCLES + 1);
	localparam logic [holdWidth-1:0] holdLast = holdWidth'(`LONG_PRESS_CYCLES - 1);
	// CSR offsets
	localparam logic [`CSR_ACTIVE_WIDTH-1:0] csrId = 'h00;
	localparam logic [`CSR_ACTIVE_WIDTH-1:0] csrLevel = 'h04;
	localparam logic [`CSR_ACTIVE_WIDTH-1:0] csrEdge = 'h08;
	localparam logic [`CSR_ACTIVE_WIDTH-1:0] csrLong = 'h0C;
	localparam logic [`CSR_ACTIVE_WIDTH-1:0] csrGpio = 'h10;

	logic							blockHit;
	logic							csrWr;
	logic [`CSR_ACTIVE_WIDTH-1:0]	csrSel;
	logic [`EXT_SW_NUM-1:0]			swMeta;
	logic [`EXT_SW_NUM-1:0]			swLevel;
	logic [`EXT_SW_NUM-1:0]			swPrev;
	logic [`EXT_SW_NUM-1:0]			swRise;
	logic [`EXT_SW_NUM-1:0]			longHit;
	logic [`EXT_SW_NUM-1:0]			edgeFlag;
	logic [`EXT_SW_NUM-1:0]			longFlag;
	logic [`EXT_SW_NUM-1:0]			edgeClr;
	logic [`EXT_SW_NUM-1:0]			longClr;
	logic [holdWidth-1:0]			holdCnt [`EXT_SW_NUM];
	usiWordT						rdNext;

	assign blockHit = (slvAdrs.blockSel == `GPIO_ADRS_MAP);
	assign csrSel = slvAdrs.csrAdrs[`CSR_ACTIVE_WIDTH-1:0];
	assign csrWr = slvWr & blockHit;
	// Write 1 to clear
	assign edgeClr = (csrWr && csrSel == csrEdge) ? slvWd[`EXT_SW_NUM-1:0] : '0;
	assign longClr = (csrWr && csrSel == csrLong) ? slvWd[`EXT_SW_NUM-1:0] : '0;
	assign swRise = swLevel & ~swPrev;

	// One cycle hit as a counter crosses the threshold
	always_comb
	begin
		for (int i = 0; i < `EXT_SW_NUM; i++)
		begin
			longHit[i] = swLevel[i] && (holdCnt[i] == holdLast);
		end
	end

	// ----------------------------------------------------------
	// Switch sync, flags and GPIO register
	// ----------------------------------------------------------
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			swMeta <= '0;
			swLevel <= '0;
			swPrev <= '0;
			edgeFlag <= '0;
			longFlag <= '0;
			oGpio <= '0;
			for (int i = 0; i < `EXT_SW_NUM; i++)
			begin
				holdCnt[i] <= '0;
			end
		end
		else
		begin
			swMeta <= iPushSw;
			swLevel <= swMeta;
			swPrev <= swLevel;
			// New events win over a clear in the same cycle
			edgeFlag <= (edgeFlag & ~edgeClr) | swRise;
			longFlag <= (longFlag & ~longClr) | longHit;
			// Hold counter saturates one past the threshold
			for (int i = 0; i < `EXT_SW_NUM; i++)
			begin
				if (!swLevel[i])
					holdCnt[i] <= '0;
				else if (holdCnt[i] != holdWidth'(`LONG_PRESS_CYCLES))
					holdCnt[i] <= holdCnt[i] + 1'b1;
			end
			if (csrWr && csrSel == csrGpio)
			begin
				oGpio <= slvWd[`GPIO_WIDTH-1:0];
			end
		end
	end

	// ----------------------------------------------------------
	// CSR read
	// ----------------------------------------------------------
	always_comb
	begin
		case (csrSel)
			csrId:		rdNext = {`SYSTEM_VERSION, `CUSTOM_CODE};
			csrLevel:	rdNext = usiWordT'(swLevel);
			csrEdge:	rdNext = usiWordT'(edgeFlag);
			csrLong:	rdNext = usiWordT'(longFlag);
			csrGpio:	rdNext = usiWordT'(oGpio);
			default:	rdNext = '0;
		endcase
	end

	// Read word ready one cycle after slvRd
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			gpioRd <= '0;
		end
		else if (slvRd && blockHit)
		begin
			gpioRd <= rdNext;
		end
	end

endmodule

// File: verilog/sysTimerBlock.sv
`timescale 1ns/1ps
`include "tryPad_config.svh"

module sysTimerBlock
(
	input  logic				iMCLK,
	input  logic				qnARST,
	input  tryPadPkg::usiAdrsT	slvAdrs,
	input  tryPadPkg::usiWordT	slvWd,
	input  logic				slvWr,
	input  logic				slvRd,
	output tryPadPkg::usiWordT	timerRd,
	output logic				oTimerIrq
);
	import tryPadPkg::*;

	// CSR offsets
	localparam logic [`CSR_ACTIVE_WIDTH-1:0] csrCount = 'h00;
	localparam logic [`CSR_ACTIVE_WIDTH-1:0] csrCtrl = 'h04;
	localparam logic [`CSR_ACTIVE_WIDTH-1:0] csrCmp = 'h08;
	localparam logic [`CSR_ACTIVE_WIDTH-1:0] csrStat = 'h0C;

	logic							blockHit;
	logic							csrWr;
	logic [`CSR_ACTIVE_WIDTH-1:0]	csrSel;
	logic							cntEn;
	logic							irqEn;
	logic							matchFlag;
	logic							statClr;
	usiWordT						cntQ;
	usiWordT						cmpQ;
	usiWordT						rdNext;

	assign blockHit = (slvAdrs.blockSel == `TIMER_ADRS_MAP);
	assign csrSel = slvAdrs.csrAdrs[`CSR_ACTIVE_WIDTH-1:0];
	assign csrWr = slvWr & blockHit;
	assign statClr = csrWr && csrSel == csrStat && slvWd[0];

	// ----------------------------------------------------------
	// Counter, control and match
	// ----------------------------------------------------------
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			cntQ <= '0;
			cmpQ <= '0;
			cntEn <= 1'b0;
			irqEn <= 1'b0;
			matchFlag <= 1'b0;
		end
		else
		begin
			// Any write to the counter restarts it from zero
			if (csrWr && csrSel == csrCount)
				cntQ <= '0;
			else if (cntEn)
				cntQ <= cntQ + 1'b1;
			if (csrWr && csrSel == csrCtrl)
			begin
				cntEn <= slvWd[0];
				irqEn <= slvWd[1];
			end
			if (csrWr && csrSel == csrCmp)
			begin
				cmpQ <= slvWd;
			end
			// Sticky, only a running counter can match
			matchFlag <= (matchFlag & ~statClr) | (cntEn & (cntQ == cmpQ));
		end
	end

	assign oTimerIrq = matchFlag & irqEn;

	// ----------------------------------------------------------
	// CSR read
	// ----------------------------------------------------------
	always_comb
	begin
		case (csrSel)
			csrCount:	rdNext = cntQ;
			csrCtrl:	rdNext = usiWordT'({irqEn, cntEn});
			csrCmp:		rdNext = cmpQ;
			csrStat:	rdNext = usiWordT'(matchFlag);
			default:	rdNext = '0;
		endcase
	end

	// Read word ready one cycle after slvRd
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			timerRd <= '0;
		end
		else if (slvRd && blockHit)
		begin
			timerRd <= rdNext;
		end
	end

endmodule

// File: verilog/tryPadTop.sv
`timescale 1ns/1ps
`include "tryPad_config.svh"

module tryPadTop
(
	input  logic					iMCLK,
	input  logic					qnARST,
	input  logic					iSpiSck,
	input  logic					iSpiMosi,
	input  logic					iSpiCsN,
	input  logic [`EXT_SW_NUM-1:0]	iPushSw,
	output logic					oSpiMiso,
	output logic [`GPIO_WIDTH-1:0]	oGpio,
	output logic					oTimerIrq
);
	import tryPadPkg::*;

	// Master side of the register bus
	usiAdrsT	usiAdrs;
	usiWordT	usiWd;
	logic		usiWr;
	logic		usiRd;
	usiWordT	usiRdData;
	logic		usiRdVd;
	// Slave side broadcast and read returns
	usiAdrsT	slvAdrs;
	usiWordT	slvWd;
	logic		slvWr;
	logic		slvRd;
	usiWordT	gpioRd;
	usiWordT	timerRd;

	// ----------------------------------------------------------
	// Host SPI bridge, the only bus master
	// ----------------------------------------------------------
	spiCsrBridge uBridge
	(
		.iMCLK(iMCLK),			.qnARST(qnARST),
		.iSpiSck(iSpiSck),		.iSpiMosi(iSpiMosi),
		.iSpiCsN(iSpiCsN),		.oSpiMiso(oSpiMiso),
		.usiAdrs(usiAdrs),		.usiWd(usiWd),
		.usiWr(usiWr),			.usiRd(usiRd),
		.usiRdData(usiRdData),	.usiRdVd(usiRdVd)
	);

	usiBus uBus
	(
		.iMCLK(iMCLK),			.qnARST(qnARST),
		.usiAdrs(usiAdrs),		.usiWd(usiWd),
		.usiWr(usiWr),			.usiRd(usiRd),
		.gpioRd(gpioRd),		.timerRd(timerRd),
		.slvAdrs(slvAdrs),		.slvWd(slvWd),
		.slvWr(slvWr),			.slvRd(slvRd),
		.usiRdData(usiRdData),	.usiRdVd(usiRdVd)
	);

	// ----------------------------------------------------------
	// Peer register blocks
	// ----------------------------------------------------------
	switchGpioBlock uGpio
	(
		.iMCLK(iMCLK),			.qnARST(qnARST),
		.slvAdrs(slvAdrs),		.slvWd(slvWd),
		.slvWr(slvWr),			.slvRd(slvRd),
		.iPushSw(iPushSw),		.gpioRd(gpioRd),
		.oGpio(oGpio)
	);

	sysTimerBlock uTimer
	(
		.iMCLK(iMCLK),			.qnARST(qnARST),
		.slvAdrs(slvAdrs),		.slvWd(slvWd),
		.slvWr(slvWr),			.slvRd(slvRd),
		.timerRd(timerRd),		.oTimerIrq(oTimerIrq)
	);

endmodule

// File: sim/tryPad_props.sv
`timescale 1ns/1ps
`include "tryPad_config.svh"

module tryPadProps
(
	input logic					iMCLK,
	input logic					qnARST,
	input logic					usiWr,
	input logic					usiRd,
	input logic					usiRdVd,
	input tryPadPkg::usiAdrsT	slvAdrs,
	input tryPadPkg::usiWordT	slvWd,
	input logic					slvWr,
	input logic					oTimerIrq
);

	// Timer control offset, bit 1 is the irq enable
	localparam logic [`CSR_ACTIVE_WIDTH-1:0] timerCtrl = 'h04;

	// Irq enable as last written over the slave bus
	logic	irqEnSeen;

	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			irqEnSeen <= 1'b0;
		end
		else if (slvWr && slvAdrs.blockSel == `TIMER_ADRS_MAP
			&& slvAdrs.csrAdrs[`CSR_ACTIVE_WIDTH-1:0] == timerCtrl)
		begin
			irqEnSeen <= slvWd[1];
		end
	end

	// Read return exactly two cycles after the request
	rdLatency: assert property (@(posedge iMCLK) disable iff (!qnARST)
		usiRdVd == $past(usiRd, 2))
	else $error("usiRdVd does not follow usiRd by exactly two cycles");

	// One access per cycle from the bridge
	noWrRdOverlap: assert property (@(posedge iMCLK) disable iff (!qnARST)
		!(usiWr && usiRd))
	else $error("usiWr and usiRd high in the same cycle");

	// Irq gated by its enable
	irqGated: assert property (@(posedge iMCLK) disable iff (!qnARST)
		oTimerIrq |-> irqEnSeen)
	else $error("oTimerIrq high while the interrupt enable is 0");

endmodule

bind tryPadTop tryPadProps uProps
(
	.iMCLK(iMCLK),
	.qnARST(qnARST),
	.usiWr(usiWr),
	.usiRd(usiRd),
	.usiRdVd(usiRdVd),
	.slvAdrs(slvAdrs),
	.slvWd(slvWd),
	.slvWr(slvWr),
	.oTimerIrq(oTimerIrq)
);

// File: sim/tryPadTb.sv
`timescale 1ns/1ps
`include "tryPad_config.svh"

module tryPadTb;

	// SCK half period in iMCLK cycles
	localparam int halfPeriod = 6;
	// Switch sync settle after a change
	localparam int settleCycles = 8;
	localparam int maxRecords = 32;
	// Switch block CSR offsets
	localparam logic [15:0] csrLevel = 16'h0004;
	localparam logic [15:0] csrEdge = 16'h0008;
	localparam logic [15:0] csrLong = 16'h000C;

	logic							iMCLK;
	logic							qnARST;
	logic							iSpiSck;
	logic							iSpiMosi;
	logic							iSpiCsN;
	logic [`EXT_SW_NUM-1:0]			iPushSw;
	logic							oSpiMiso;
	logic [`GPIO_WIDTH-1:0]			oGpio;
	logic							oTimerIrq;

	// Five words per record: op, block, CSR, data, expected
	logic [31:0]					stimMem [0:5*maxRecords-1];
	logic [31:0]					lcgState;
	logic							runDone;
	int								recIdx;

	tryPadTop DUT
	(
		.iMCLK(iMCLK),			.qnARST(qnARST),
		.iSpiSck(iSpiSck),		.iSpiMosi(iSpiMosi),
		.iSpiCsN(iSpiCsN),		.iPushSw(iPushSw),
		.oSpiMiso(oSpiMiso),	.oGpio(oGpio),
		.oTimerIrq(oTimerIrq)
	);

	// 40 ns clock
	initial
	begin
		iMCLK = 1'b0;
	end

	always #20 iMCLK = ~iMCLK;

	// ----------------------------------------------------------
	// Failure reporting
	// ----------------------------------------------------------
	task automatic stopFail();
		$display("Simulation failed");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic reportError(input string msg);
		$display("** Error at %0t ns: %s", $time, msg);
		stopFail();
	endtask

	task automatic valueError(input string what, input logic [31:0] got,
		input logic [31:0] expVal);
		reportError($sformatf("%s read %h, expected %h", what, got, expVal));
	endtask

	// Protocol, timeout and setup failures
	task automatic abortRun(input string msg);
		$display("Failure at %0t ns: %s", $time, msg);
		stopFail();
	endtask

	// ----------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------
	function automatic logic [31:0] lcgStep(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Write flag, 12 reserved bits, block, CSR offset
	function automatic logic [31:0] makeHeader(input logic wr, input logic [2:0] blk,
		input logic [15:0] csr);
		return {wr, 12'h000, blk, csr};
	endfunction

	task automatic waitCycles(input int n);
		repeat (n) @(negedge iMCLK);
	endtask

	// One 64 bit mode 0 frame, miso taken at each SCK rise
	task automatic spiXfer(input logic [31:0] hdr, input logic [31:0] wd,
		output logic [31:0] rdWord);
		logic [63:0] txBits;
		logic [63:0] rxBits;
		txBits = {hdr, wd};
		rxBits = '0;
		// Deselected slave keeps miso low
		assert (oSpiMiso === 1'b0)
		else abortRun("oSpiMiso active while the SPI slave is deselected");
		@(negedge iMCLK);
		iSpiCsN = 1'b0;
		iSpiSck = 1'b0;
		for (int i = 63; i >= 0; i--)
		begin
			iSpiMosi = txBits[i];
			waitCycles(halfPeriod);
			iSpiSck = 1'b1;
			rxBits = {rxBits[62:0], oSpiMiso};
			waitCycles(halfPeriod);
			iSpiSck = 1'b0;
		end
		waitCycles(halfPeriod);
		iSpiCsN = 1'b1;
		iSpiMosi = 1'b0;
		waitCycles(2 * halfPeriod);
		rdWord = rxBits[31:0];
	endtask

	task automatic spiWrite(input logic [2:0] blk, input logic [15:0] csr,
		input logic [31:0] data);
		logic [31:0] unused;
		spiXfer(makeHeader(1'b1, blk, csr), data, unused);
	endtask

	task automatic spiRead(input logic [2:0] blk, input logic [15:0] csr,
		output logic [31:0] data);
		spiXfer(makeHeader(1'b0, blk, csr), 32'h0, data);
	endtask

	task automatic checkRead(input logic [2:0] blk, input logic [15:0] csr,
		input logic [31:0] expVal, input string what);
		logic [31:0] got;
		spiRead(blk, csr, got);
		assert (got === expVal)
		else valueError($sformatf("%s (block %0d CSR %h)", what, blk, csr), got, expVal);
	endtask

	// Nonzero 12 bit mask from the upper LCG bits
	task automatic nextMask(output logic [`EXT_SW_NUM-1:0] mask);
		lcgState = lcgStep(lcgState);
		mask = lcgState[`EXT_SW_NUM+15:16];
		if (mask == '0)
			mask = 1;
	endtask

	// ----------------------------------------------------------
	// Record operations
	// ----------------------------------------------------------
	task automatic gpioLoop(input logic [2:0] blk, input logic [15:0] csr,
		input logic [31:0] count);
		logic [31:0] pattern;
		for (int n = 0; n < int'(count); n++)
		begin
			lcgState = lcgStep(lcgState);
			// Halves swapped, low LCG bits are weak
			pattern = {lcgState[15:0], lcgState[31:16]};
			spiWrite(blk, csr, pattern);
			assert (oGpio === pattern[`GPIO_WIDTH-1:0])
			else valueError("oGpio pins", 32'(oGpio), 32'(pattern[`GPIO_WIDTH-1:0]));
			checkRead(blk, csr, 32'(pattern[`GPIO_WIDTH-1:0]), "GPIO readback");
		end
	endtask

	task automatic shortPress(input logic [2:0] blk, input logic [31:0] cycles);
		logic [`EXT_SW_NUM-1:0] mask;
		nextMask(mask);
		iPushSw = mask;
		waitCycles(int'(cycles));
		iPushSw = '0;
		waitCycles(settleCycles);
		checkRead(blk, csrEdge, 32'(mask), "edge flags after short press");
		checkRead(blk, csrLong, 32'h0, "long-press flags after short press");
		// Write 1 to clear
		spiWrite(blk, csrEdge, 32'(mask));
		checkRead(blk, csrEdge, 32'h0, "edge flags after clear");
	endtask

	task automatic longPress(input logic [2:0] blk, input logic [31:0] margin);
		logic [`EXT_SW_NUM-1:0] mask;
		nextMask(mask);
		iPushSw = mask;
		waitCycles(`LONG_PRESS_CYCLES + int'(margin));
		// Still held during these reads
		checkRead(blk, csrLevel, 32'(mask), "switch level while held");
		checkRead(blk, csrLong, 32'(mask), "long-press flags after hold");
		iPushSw = '0;
		waitCycles(settleCycles);
		spiWrite(blk, csrLong, 32'(mask));
		spiWrite(blk, csrEdge, 32'(mask));
		checkRead(blk, csrLong, 32'h0, "long-press flags after clear");
		checkRead(blk, csrEdge, 32'h0, "edge flags after clear");
	endtask

	task automatic waitIrq(input logic level, input logic [31:0] limit);
		int cnt;
		cnt = 0;
		while (oTimerIrq !== level && cnt < int'(limit))
		begin
			@(negedge iMCLK);
			cnt++;
		end
		assert (oTimerIrq === level)
		else abortRun($sformatf("timeout waiting for oTimerIrq to become %0d", level));
	endtask

	task automatic counterRises(input logic [2:0] blk, input logic [15:0] csr);
		logic [31:0] first;
		logic [31:0] second;
		spiRead(blk, csr, first);
		spiRead(blk, csr, second);
		assert (second > first)
		else reportError($sformatf("counter did not increase, first %h second %h",
			first, second));
	endtask

	task automatic runRecord(input int idx, output logic isEnd);
		logic [31:0] op;
		logic [2:0]  blk;
		logic [15:0] csr;
		logic [31:0] data;
		logic [31:0] expVal;
		op = stimMem[5*idx];
		blk = stimMem[5*idx+1][2:0];
		csr = stimMem[5*idx+2][15:0];
		data = stimMem[5*idx+3];
		expVal = stimMem[5*idx+4];
		isEnd = 1'b0;
		case (op)
			32'h0:		isEnd = 1'b1;
			32'h1:		spiWrite(blk, csr, data);
			32'h2:		checkRead(blk, csr, expVal, "CSR read");
			32'h3:
			begin
				iPushSw = data[`EXT_SW_NUM-1:0];
				waitCycles(settleCycles);
			end
			32'h4:		waitIrq(expVal[0], data);
			32'h5:		gpioLoop(blk, csr, data);
			32'h6:		shortPress(blk, data);
			32'h7:		longPress(blk, data);
			32'h8:		counterRises(blk, csr);
			default:	abortRun($sformatf("unknown stimulus operation in record %0d", idx));
		endcase
	endtask

	// ----------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------
	initial
	begin
		qnARST = 1'b0;
		iSpiSck = 1'b0;
		iSpiMosi = 1'b0;
		iSpiCsN = 1'b1;
		iPushSw = '0;
		lcgState = 32'd98;
		runDone = 1'b0;
		recIdx = 0;
		$readmemh("sim/tryPad_stim.txt", stimMem);
		// Reset held two cycles
		waitCycles(2);
		qnARST = 1'b1;
		waitCycles(2);
		assert (oGpio === '0 && oTimerIrq === 1'b0 && oSpiMiso === 1'b0)
		else abortRun("outputs not cleared by reset");
		while (!runDone)
		begin
			assert (recIdx < maxRecords)
			else abortRun("stimulus file has no end record");
			runRecord(recIdx, runDone);
			recIdx++;
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// File: sim/tryPad_stim.txt
// Columns (hex): op block csr data expected
// op: 1 write, 2 read-check, 3 switch set, 4 wait irq (data = timeout cycles),
// 5 GPIO random loop (data = count), 6 short press (data = cycles),
// 7 long press (data = margin), 8 counter increase, 0 end
// ID word and an unmapped block
2 0 0000 00000000 00015450
2 7 0000 00000000 00000000
// GPIO output patterns
5 0 0010 00000006 00000000
// Push switches
6 0 0008 00000032 00000000
7 0 000C 0000003C 00000000
3 0 0000 00000000 00000000
2 0 0004 00000000 00000000
// System timer
1 4 0000 00000000 00000000
1 4 0008 00000064 00000000
1 4 000C 00000001 00000000
1 4 0004 00000003 00000000
4 0 0000 00000400 00000001
8 4 0000 00000000 00000000
2 4 000C 00000000 00000001
1 4 000C 00000001 00000000
4 0 0000 00000040 00000000
2 4 000C 00000000 00000000
2 4 0004 00000000 00000003
0 0 0000 00000000 00000000

// File: sim.f
+incdir+include
verilog/tryPadPkg.sv
verilog/spiCsrBridge.sv
verilog/usiBus.sv
verilog/switchGpioBlock.sv
verilog/sysTimerBlock.sv
verilog/tryPadTop.sv
sim/tryPad_props.sv
sim/tryPadTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tryPadTb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert -Wall

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
